/* all.f */
rtl/cpu_types_pkg.sv
rtl/exec_pkg.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/exec_writeback.sv
rtl/exec_stage.sv
sim/exec_stage_tb.sv

/* rtl/alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational ALU
// shifts, add/sub, logic ops and set-less-than with
// negative, overflow and zero flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module alu (
  // sampling clock for the checks below
  input  logic                                  CLK,
  input  exec_pkg::aluop_t                      aluop_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      port_a_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      port_b_i,
  output logic [cpu_types_pkg::WORD_W-1:0]      port_o,
  output exec_pkg::alu_flags_t                  flags_o
);

  localparam int MSB = cpu_types_pkg::WORD_W - 1;

  logic [cpu_types_pkg::WORD_W-1:0]  sum;
  logic [cpu_types_pkg::WORD_W-1:0]  diff;
  logic [cpu_types_pkg::SHAMT_W-1:0] shamt;
  logic                              add_ovf;
  logic                              sub_ovf;
  logic                              ovf;

  assign sum   = port_a_i + port_b_i;
  assign diff  = port_a_i - port_b_i;
  assign shamt = port_b_i[cpu_types_pkg::SHAMT_W-1:0];

  // same-sign inputs, result sign flipped
  assign add_ovf = (port_a_i[MSB] == port_b_i[MSB]) && (sum[MSB] != port_a_i[MSB]);
  // opposite-sign inputs, result takes sign of b
  assign sub_ovf = (port_a_i[MSB] != port_b_i[MSB]) && (diff[MSB] != port_a_i[MSB]);

  always_comb
  begin
    port_o = '0;
    ovf    = 1'b0;
    case (aluop_i)
      exec_pkg::ALU_SLL:  port_o = port_a_i << shamt;
      exec_pkg::ALU_SRL:  port_o = port_a_i >> shamt;
      exec_pkg::ALU_ADD:
      begin
        port_o = sum;
        ovf    = add_ovf;
      end
      exec_pkg::ALU_SUB:
      begin
        port_o = diff;
        ovf    = sub_ovf;
      end
      exec_pkg::ALU_AND:  port_o = port_a_i & port_b_i;
      exec_pkg::ALU_OR:   port_o = port_a_i | port_b_i;
      exec_pkg::ALU_XOR:  port_o = port_a_i ^ port_b_i;
      exec_pkg::ALU_NOR:  port_o = ~(port_a_i | port_b_i);
      exec_pkg::ALU_SLT:
        port_o = {{MSB{1'b0}}, ($signed(port_a_i) < $signed(port_b_i))};
      exec_pkg::ALU_SLTU:
        port_o = {{MSB{1'b0}}, (port_a_i < port_b_i)};
      default:            port_o = '0;
    endcase
  end

  assign flags_o.negative = port_o[MSB];
  assign flags_o.overflow = ovf;
  assign flags_o.zero     = (port_o == '0);

  // overflow only means something for add and sub
  a_ovf_only_addsub: assert property (
    @(posedge CLK)
    !(aluop_i inside {exec_pkg::ALU_ADD, exec_pkg::ALU_SUB}) |-> !flags_o.overflow
  );

  // sub and xor give zero exactly for equal operands
  a_zero_matches: assert property (
    @(posedge CLK)
    (aluop_i inside {exec_pkg::ALU_SUB, exec_pkg::ALU_XOR}) |->
      flags_o.zero == (port_a_i == port_b_i)
  );

endmodule

/* rtl/cpu_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set types for the MIPS-style core
// opcodes, R-type funct codes, register index and the
// R/I instruction word seen two ways through one union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_types_pkg;

  // datapath width
  localparam int WORD_W = 32;

  // instruction field widths
  localparam int REG_W   = 5;
  localparam int SHAMT_W = 5;
  localparam int IMM_W   = 16;

  // LUI places the immediate in the upper half
  localparam logic [WORD_W-1:0] LUI_SHIFT = 16;

  // primary opcode
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    ADDI  = 6'h08,
    ADDIU = 6'h09,
    SLTI  = 6'h0A,
    SLTIU = 6'h0B,
    ANDI  = 6'h0C,
    ORI   = 6'h0D,
    XORI  = 6'h0E,
    LUI   = 6'h0F
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2A,
    SLTU = 6'h2B
  } funct_t;

  typedef logic [REG_W-1:0] reg_idx_t;

  typedef struct packed {
    opcode_t              opcode;
    reg_idx_t             rs;
    reg_idx_t             rt;
    reg_idx_t             rd;
    logic [SHAMT_W-1:0]   shamt;
    funct_t               funct;
  } rtype_t;

  typedef struct packed {
    opcode_t              opcode;
    reg_idx_t             rs;
    reg_idx_t             rt;
    logic [IMM_W-1:0]     imm;
  } itype_t;

  // opcode sits in the same bits in both views
  typedef union packed {
    rtype_t rtype;
    itype_t itype;
  } instr_u;

endpackage

/* rtl/exec_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage types
// ALU operation codes, flags, the operand bundle handed
// from decode and the result bundle leaving write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package exec_pkg;

  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU
  } aluop_t;

  typedef struct packed {
    logic negative;
    logic overflow;
    logic zero;
  } alu_flags_t;

  // decoded operation, one per issued instruction
  typedef struct packed {
    aluop_t                                aluop;
    logic [cpu_types_pkg::WORD_W-1:0]      port_a;
    logic [cpu_types_pkg::WORD_W-1:0]      port_b;
    cpu_types_pkg::reg_idx_t               dest;
    // set for ADD, SUB and ADDI only
    logic                                  trap_ovf;
    logic                                  illegal;
  } exec_op_t;

  typedef struct packed {
    logic [cpu_types_pkg::WORD_W-1:0]      value;
    alu_flags_t                            flags;
    cpu_types_pkg::reg_idx_t               dest;
    logic                                  wen;
    logic                                  ovf_trap;
    logic                                  illegal_trap;
  } exec_result_t;

endpackage

/* rtl/exec_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage top
// decode -> ALU -> write-back, two cycles valid to valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_stage (
  input  logic                                  CLK,
  input  logic                                  arst_n_i,
  input  logic                                  valid_i,
  input  cpu_types_pkg::instr_u                 instr_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      rs_data_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      rt_data_i,
  output logic                                  valid_o,
  output exec_pkg::exec_result_t                result_o
);

  exec_pkg::exec_op_t               op_q;
  logic                             op_valid_q;
  logic [cpu_types_pkg::WORD_W-1:0] alu_port;
  exec_pkg::alu_flags_t             alu_flags;

  instr_decode u_instr_decode (
    .CLK        (CLK),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .instr_i    (instr_i),
    .rs_data_i  (rs_data_i),
    .rt_data_i  (rt_data_i),
    .op_o       (op_q),
    .op_valid_o (op_valid_q)
  );

  alu u_alu (
    .CLK      (CLK),
    .aluop_i  (op_q.aluop),
    .port_a_i (op_q.port_a),
    .port_b_i (op_q.port_b),
    .port_o   (alu_port),
    .flags_o  (alu_flags)
  );

  exec_writeback u_exec_writeback (
    .CLK         (CLK),
    .arst_n_i    (arst_n_i),
    .op_valid_i  (op_valid_q),
    .op_i        (op_q),
    .alu_value_i (alu_port),
    .alu_flags_i (alu_flags),
    .valid_o     (valid_o),
    .result_o    (result_o)
  );

endmodule

/* rtl/exec_writeback.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute write-back
// registers the ALU result and resolves the traps, the
// destination and the register write enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_writeback (
  input  logic                                  CLK,
  input  logic                                  arst_n_i,
  input  logic                                  op_valid_i,
  input  exec_pkg::exec_op_t                    op_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      alu_value_i,
  input  exec_pkg::alu_flags_t                  alu_flags_i,
  output logic                                  valid_o,
  output exec_pkg::exec_result_t                result_o
);

  logic                             ovf_trap_d;
  logic                             wen_d;
  logic                             valid_q;
  logic                             wen_q;
  logic                             ovf_trap_q;
  logic                             illegal_trap_q;
  logic [cpu_types_pkg::WORD_W-1:0] value_q;
  exec_pkg::alu_flags_t             flags_q;
  cpu_types_pkg::reg_idx_t          dest_q;

  assign ovf_trap_d = op_i.trap_ovf & alu_flags_i.overflow;

  // r0 is hardwired, writes to it are dropped
  assign wen_d = op_valid_i & ~ovf_trap_d & ~op_i.illegal & (op_i.dest != '0);

  always_ff @(posedge CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_q        <= 1'b0;
      wen_q          <= 1'b0;
      ovf_trap_q     <= 1'b0;
      illegal_trap_q <= 1'b0;
    end
    else
    begin
      valid_q        <= op_valid_i;
      wen_q          <= wen_d;
      ovf_trap_q     <= op_valid_i & ovf_trap_d;
      illegal_trap_q <= op_valid_i & op_i.illegal;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (op_valid_i)
    begin
      value_q <= alu_value_i;
      flags_q <= alu_flags_i;
      dest_q  <= op_i.dest;
    end
  end

  assign valid_o               = valid_q;
  assign result_o.value        = value_q;
  assign result_o.flags        = flags_q;
  assign result_o.dest         = dest_q;
  assign result_o.wen          = wen_q;
  assign result_o.ovf_trap     = ovf_trap_q;
  assign result_o.illegal_trap = illegal_trap_q;

  // a trapped instruction never reaches the register file
  a_wen_no_trap: assert property (
    @(posedge CLK) disable iff (!arst_n_i)
    result_o.wen |-> valid_o && !(result_o.ovf_trap || result_o.illegal_trap)
  );

endmodule

/* rtl/instr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decode for the execute stage
// turns a strobed R/I-type word and the two register
// values into a registered ALU operand bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module instr_decode (
  input  logic                                  CLK,
  input  logic                                  arst_n_i,
  input  logic                                  valid_i,
  input  cpu_types_pkg::instr_u                 instr_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      rs_data_i,
  input  logic [cpu_types_pkg::WORD_W-1:0]      rt_data_i,
  output exec_pkg::exec_op_t                    op_o,
  output logic                                  op_valid_o
);

  logic [cpu_types_pkg::WORD_W-1:0] imm_sext;
  logic [cpu_types_pkg::WORD_W-1:0] imm_zext;
  logic [cpu_types_pkg::WORD_W-1:0] shamt_zext;
  exec_pkg::exec_op_t               op_d;
  exec_pkg::exec_op_t               op_q;
  logic                             op_valid_q;

  // immediate and shift amount extensions
  assign imm_sext = {{(cpu_types_pkg::WORD_W - cpu_types_pkg::IMM_W)
                      {instr_i.itype.imm[cpu_types_pkg::IMM_W-1]}},
                     instr_i.itype.imm};
  assign imm_zext = {{(cpu_types_pkg::WORD_W - cpu_types_pkg::IMM_W){1'b0}},
                     instr_i.itype.imm};
  assign shamt_zext = {{(cpu_types_pkg::WORD_W - cpu_types_pkg::SHAMT_W){1'b0}},
                       instr_i.rtype.shamt};

  always_comb
  begin
    op_d          = '0;
    op_d.aluop    = exec_pkg::ALU_ADD;
    op_d.port_a   = rs_data_i;
    op_d.port_b   = imm_sext;
    op_d.dest     = instr_i.itype.rt;
    op_d.trap_ovf = 1'b0;
    op_d.illegal  = 1'b0;

    if (instr_i.rtype.opcode == cpu_types_pkg::RTYPE)
    begin
      op_d.dest   = instr_i.rtype.rd;
      op_d.port_b = rt_data_i;
      case (instr_i.rtype.funct)
        cpu_types_pkg::SLL:
        begin
          op_d.aluop  = exec_pkg::ALU_SLL;
          op_d.port_a = rt_data_i;
          op_d.port_b = shamt_zext;
        end
        cpu_types_pkg::SRL:
        begin
          op_d.aluop  = exec_pkg::ALU_SRL;
          op_d.port_a = rt_data_i;
          op_d.port_b = shamt_zext;
        end
        cpu_types_pkg::ADD:
        begin
          op_d.aluop    = exec_pkg::ALU_ADD;
          op_d.trap_ovf = 1'b1;
        end
        cpu_types_pkg::ADDU: op_d.aluop = exec_pkg::ALU_ADD;
        cpu_types_pkg::SUB:
        begin
          op_d.aluop    = exec_pkg::ALU_SUB;
          op_d.trap_ovf = 1'b1;
        end
        cpu_types_pkg::SUBU: op_d.aluop = exec_pkg::ALU_SUB;
        cpu_types_pkg::AND:  op_d.aluop = exec_pkg::ALU_AND;
        cpu_types_pkg::OR:   op_d.aluop = exec_pkg::ALU_OR;
        cpu_types_pkg::XOR:  op_d.aluop = exec_pkg::ALU_XOR;
        cpu_types_pkg::NOR:  op_d.aluop = exec_pkg::ALU_NOR;
        cpu_types_pkg::SLT:  op_d.aluop = exec_pkg::ALU_SLT;
        cpu_types_pkg::SLTU: op_d.aluop = exec_pkg::ALU_SLTU;
        default:             op_d.illegal = 1'b1;
      endcase
    end
    else
    begin
      case (instr_i.itype.opcode)
        cpu_types_pkg::ADDI:
        begin
          op_d.aluop    = exec_pkg::ALU_ADD;
          op_d.trap_ovf = 1'b1;
        end
        cpu_types_pkg::ADDIU: op_d.aluop = exec_pkg::ALU_ADD;
        cpu_types_pkg::SLTI:  op_d.aluop = exec_pkg::ALU_SLT;
        cpu_types_pkg::SLTIU: op_d.aluop = exec_pkg::ALU_SLTU;
        cpu_types_pkg::ANDI:
        begin
          op_d.aluop  = exec_pkg::ALU_AND;
          op_d.port_b = imm_zext;
        end
        cpu_types_pkg::ORI:
        begin
          op_d.aluop  = exec_pkg::ALU_OR;
          op_d.port_b = imm_zext;
        end
        cpu_types_pkg::XORI:
        begin
          op_d.aluop  = exec_pkg::ALU_XOR;
          op_d.port_b = imm_zext;
        end
        // LUI rides on the shifter
        cpu_types_pkg::LUI:
        begin
          op_d.aluop  = exec_pkg::ALU_SLL;
          op_d.port_a = imm_zext;
          op_d.port_b = cpu_types_pkg::LUI_SHIFT;
        end
        default: op_d.illegal = 1'b1;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      op_valid_q <= 1'b0;
      op_q       <= '0;
    end
    else
    begin
      op_valid_q <= valid_i;
      if (valid_i)
        op_q <= op_d;
    end
  end

  assign op_o       = op_q;
  assign op_valid_o = op_valid_q;

  // one decoded op per strobe, never a spontaneous one
  a_no_spurious_valid: assert property (
    @(posedge CLK) disable iff (!arst_n_i)
    !valid_i |=> !op_valid_o
  );

endmodule

/* sim/exec_stage_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the execute stage
// directed R/I-type, trap and back-to-back tests checked
// against a reference model through an expected queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_stage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                          CLK = 1'b0;
  logic                          arst_n_i;
  logic                          valid_i;
  cpu_types_pkg::instr_u         instr_i;
  logic [31:0]                   rs_data_i;
  logic [31:0]                   rt_data_i;
  logic                          valid_o;
  exec_pkg::exec_result_t        result_o;

  exec_pkg::exec_result_t        exp_q [$];
  int unsigned                   due_q [$];
  exec_pkg::exec_result_t        mon_exp;
  int unsigned                   mon_due;
  int unsigned                   neg_cnt = 0;
  logic [31:0]                   lcg_state = 32'h342b_7ff8;

  cpu_types_pkg::funct_t r_ops [12] = '{
    cpu_types_pkg::SLL, cpu_types_pkg::SRL, cpu_types_pkg::ADD, cpu_types_pkg::SUB,
    cpu_types_pkg::AND, cpu_types_pkg::OR, cpu_types_pkg::XOR, cpu_types_pkg::NOR,
    cpu_types_pkg::SLT, cpu_types_pkg::SLTU, cpu_types_pkg::ADDU, cpu_types_pkg::SUBU
  };
  cpu_types_pkg::opcode_t i_ops [8] = '{
    cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU, cpu_types_pkg::SLTI, cpu_types_pkg::SLTIU,
    cpu_types_pkg::ANDI, cpu_types_pkg::ORI, cpu_types_pkg::XORI, cpu_types_pkg::LUI
  };

  exec_stage u_exec_stage (
    .CLK       (CLK),
    .arst_n_i  (arst_n_i),
    .valid_i   (valid_i),
    .instr_i   (instr_i),
    .rs_data_i (rs_data_i),
    .rt_data_i (rt_data_i),
    .valid_o   (valid_o),
    .result_o  (result_o)
  );

  always #2 CLK = ~CLK;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic cpu_types_pkg::instr_u make_r(
    input cpu_types_pkg::funct_t   funct,
    input cpu_types_pkg::reg_idx_t rs,
    input cpu_types_pkg::reg_idx_t rt,
    input cpu_types_pkg::reg_idx_t rd,
    input logic [4:0]              shamt
  );
    cpu_types_pkg::instr_u w;
    w.rtype.opcode = cpu_types_pkg::RTYPE;
    w.rtype.rs     = rs;
    w.rtype.rt     = rt;
    w.rtype.rd     = rd;
    w.rtype.shamt  = shamt;
    w.rtype.funct  = funct;
    return w;
  endfunction

  function automatic cpu_types_pkg::instr_u make_i(
    input cpu_types_pkg::opcode_t  opcode,
    input cpu_types_pkg::reg_idx_t rs,
    input cpu_types_pkg::reg_idx_t rt,
    input logic [15:0]             imm
  );
    cpu_types_pkg::instr_u w;
    w.itype.opcode = opcode;
    w.itype.rs     = rs;
    w.itype.rt     = rt;
    w.itype.imm    = imm;
    return w;
  endfunction

  function automatic cpu_types_pkg::instr_u rand_instr();
    logic [31:0] r;
    r = next_rand();
    if (r[31])
      return make_r(r_ops[r[7:0] % 12], r[12:8], r[17:13], r[22:18], r[27:23]);
    else
      return make_i(i_ops[r[7:0] % 8], r[12:8], r[17:13], r[30:15]);
  endfunction

  // reference model, written from the instruction set rules
  function automatic exec_pkg::exec_result_t model(
    input cpu_types_pkg::instr_u ins,
    input logic [31:0]           rs,
    input logic [31:0]           rt
  );
    exec_pkg::exec_result_t  r;
    cpu_types_pkg::reg_idx_t dest;
    logic [31:0]             sx;
    logic [31:0]             zx;
    logic [31:0]             v;
    logic [32:0]             wide;
    logic                    ovf;
    logic                    traps;
    logic                    bad;
    sx    = {{16{ins.itype.imm[15]}}, ins.itype.imm};
    zx    = {16'h0000, ins.itype.imm};
    v     = '0;
    wide  = '0;
    ovf   = 1'b0;
    traps = 1'b0;
    bad   = 1'b0;
    if (ins.rtype.opcode == cpu_types_pkg::RTYPE)
    begin
      dest = ins.rtype.rd;
      case (ins.rtype.funct)
        cpu_types_pkg::SLL: v = rt << ins.rtype.shamt;
        cpu_types_pkg::SRL: v = rt >> ins.rtype.shamt;
        cpu_types_pkg::ADD, cpu_types_pkg::ADDU:
        begin
          wide  = {rs[31], rs} + {rt[31], rt};
          traps = (ins.rtype.funct == cpu_types_pkg::ADD);
        end
        cpu_types_pkg::SUB, cpu_types_pkg::SUBU:
        begin
          wide  = {rs[31], rs} - {rt[31], rt};
          traps = (ins.rtype.funct == cpu_types_pkg::SUB);
        end
        cpu_types_pkg::AND:  v = rs & rt;
        cpu_types_pkg::OR:   v = rs | rt;
        cpu_types_pkg::XOR:  v = rs ^ rt;
        cpu_types_pkg::NOR:  v = ~(rs | rt);
        cpu_types_pkg::SLT:  v = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
        cpu_types_pkg::SLTU: v = (rs < rt) ? 32'd1 : 32'd0;
        default:             bad = 1'b1;
      endcase
      if (ins.rtype.funct inside {cpu_types_pkg::ADD, cpu_types_pkg::ADDU,
                                  cpu_types_pkg::SUB, cpu_types_pkg::SUBU})
      begin
        v   = wide[31:0];
        ovf = wide[32] ^ wide[31];
      end
    end
    else
    begin
      dest = ins.itype.rt;
      case (ins.itype.opcode)
        cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU:
        begin
          wide  = {rs[31], rs} + {sx[31], sx};
          v     = wide[31:0];
          ovf   = wide[32] ^ wide[31];
          traps = (ins.itype.opcode == cpu_types_pkg::ADDI);
        end
        cpu_types_pkg::SLTI:  v = ($signed(rs) < $signed(sx)) ? 32'd1 : 32'd0;
        cpu_types_pkg::SLTIU: v = (rs < sx) ? 32'd1 : 32'd0;
        cpu_types_pkg::ANDI:  v = rs & zx;
        cpu_types_pkg::ORI:   v = rs | zx;
        cpu_types_pkg::XORI:  v = rs ^ zx;
        cpu_types_pkg::LUI:   v = {ins.itype.imm, 16'h0000};
        default:              bad = 1'b1;
      endcase
    end
    r.value          = v;
    r.flags.negative = v[31];
    r.flags.overflow = ovf;
    r.flags.zero     = (v == 32'h0);
    r.dest           = dest;
    r.ovf_trap       = traps & ovf;
    r.illegal_trap   = bad;
    r.wen            = !(r.ovf_trap || bad) && (dest != 5'd0);
    return r;
  endfunction

  task automatic check_result(
    input string                  name,
    input exec_pkg::exec_result_t got,
    input exec_pkg::exec_result_t exp
  );
    logic differs;
    // value and flags of an illegal word carry no meaning
    if (exp.illegal_trap)
      differs = {got.dest, got.wen, got.ovf_trap, got.illegal_trap}
                !== {exp.dest, exp.wen, exp.ovf_trap, exp.illegal_trap};
    else
      differs = (got !== exp);
    if (differs)
    begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_flags(
    input string                name,
    input exec_pkg::alu_flags_t got,
    input exec_pkg::alu_flags_t exp
  );
    if (got !== exp)
    begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // result due three negedges after the issuing posedge
  task automatic issue(
    input cpu_types_pkg::instr_u ins,
    input logic [31:0]           rs,
    input logic [31:0]           rt
  );
    @(posedge CLK);
    valid_i   <= 1'b1;
    instr_i   <= ins;
    rs_data_i <= rs;
    rt_data_i <= rt;
    exp_q.push_back(model(ins, rs, rt));
    due_q.push_back(neg_cnt + 3);
  endtask

  task automatic drain();
    int waited;
    @(posedge CLK);
    valid_i <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20)
    begin
      @(posedge CLK);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout waiting for valid_o, %0d results outstanding", exp_q.size());
      $display("Simulation FAILED");
      $fatal(1, "stopped on timeout");
    end
  endtask

  task automatic run_single(
    input cpu_types_pkg::instr_u ins,
    input logic [31:0]           rs,
    input logic [31:0]           rt
  );
    issue(ins, rs, rt);
    drain();
  endtask

  // output side, sampled away from the rising edge
  always @(negedge CLK)
  begin
    neg_cnt = neg_cnt + 1;
    if (valid_o === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        $display("valid_o raised with no instruction in flight");
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
      end
      else
      begin
        mon_exp = exp_q.pop_front();
        mon_due = due_q.pop_front();
        if (mon_due != neg_cnt)
        begin
          $display("valid_o came early, at cycle %0d instead of %0d", neg_cnt, mon_due);
          $display("Simulation FAILED");
          $fatal(1, "stopped at first error");
        end
        else
        begin
          if (!mon_exp.illegal_trap)
            check_flags("result_o.flags", result_o.flags, mon_exp.flags);
          check_result("result_o", result_o, mon_exp);
        end
      end
    end
    else
    begin
      check_valid("result_o.wen", result_o.wen, 1'b0);
      if (due_q.size() != 0 && due_q[0] <= neg_cnt)
      begin
        $display("valid_o missing two cycles after valid_i");
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
      end
    end
  end

  task automatic reset_quiet();
    int i;
    for (i = 0; i < 8; i++)
    begin
      @(negedge CLK);
      check_valid("valid_o", valid_o, 1'b0);
      check_valid("result_o.wen", result_o.wen, 1'b0);
    end
    @(posedge CLK);
    arst_n_i <= 1'b1;
    for (i = 0; i < 4; i++)
    begin
      @(negedge CLK);
      check_valid("valid_o", valid_o, 1'b0);
      check_valid("result_o.wen", result_o.wen, 1'b0);
    end
  endtask

  task automatic rtype_ops();
    logic [31:0] pair_a [4];
    logic [31:0] pair_b [4];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sel;
    int          i;
    int          j;
    pair_a = '{32'h0000_0007, 32'h8000_0007, 32'h0000_0007, 32'h8000_0007};
    pair_b = '{32'h0000_0007, 32'h0000_0007, 32'h8000_0007, 32'h8000_0007};
    for (i = 0; i < 12; i++)
      for (j = 0; j < 4; j++)
        run_single(make_r(r_ops[i], 5'd1, 5'd2, 5'(i + 3), pair_b[j][4:0]),
                   pair_a[j], pair_b[j]);
    // random operands, rd may land on r0
    for (i = 0; i < 24; i++)
    begin
      a   = next_rand();
      b   = next_rand();
      sel = next_rand();
      run_single(make_r(r_ops[sel[7:0] % 12], 5'd1, 5'd2, sel[12:8], sel[17:13]), a, b);
    end
  endtask

  task automatic itype_ops();
    logic [15:0] imms [4];
    logic [31:0] rsv  [2];
    int          i;
    int          j;
    int          k;
    imms = '{16'h0005, 16'hFFF0, 16'h7FFF, 16'h8000};
    rsv  = '{32'h0000_0010, 32'h8000_0007};
    for (i = 0; i < 8; i++)
      for (j = 0; j < 4; j++)
        for (k = 0; k < 2; k++)
          run_single(make_i(i_ops[i], 5'd4, 5'(i + 8), imms[j]), rsv[k], 32'hDEAD_BEEF);
  endtask

  task automatic trap_cases();
    run_single(make_r(cpu_types_pkg::ADD, 5'd1, 5'd2, 5'd10, 5'd0), 32'h7FFF_FFFF, 32'h1);
    run_single(make_r(cpu_types_pkg::SUB, 5'd1, 5'd2, 5'd10, 5'd0), 32'h8000_0000, 32'h1);
    run_single(make_i(cpu_types_pkg::ADDI, 5'd1, 5'd11, 16'h0001), 32'h7FFF_FFFF, 32'h0);
    run_single(make_i(cpu_types_pkg::ADDI, 5'd1, 5'd11, 16'hFFFF), 32'h8000_0000, 32'h0);
    run_single(make_r(cpu_types_pkg::ADDU, 5'd1, 5'd2, 5'd12, 5'd0), 32'h7FFF_FFFF, 32'h1);
    run_single(make_r(cpu_types_pkg::SUBU, 5'd1, 5'd2, 5'd12, 5'd0), 32'h8000_0000, 32'h1);
    run_single(make_i(cpu_types_pkg::ADDIU, 5'd1, 5'd13, 16'h0001), 32'h7FFF_FFFF, 32'h0);
    run_single(make_i(cpu_types_pkg::ADDIU, 5'd1, 5'd13, 16'hFFFF), 32'h8000_0000, 32'h0);
    // undefined opcode, then undefined funct
    run_single(make_i(cpu_types_pkg::opcode_t'(6'h3F), 5'd1, 5'd14, 16'h1234), 32'h5, 32'h6);
    run_single(make_r(cpu_types_pkg::funct_t'(6'h3F), 5'd1, 5'd2, 5'd15, 5'd0), 32'h5, 32'h6);
    run_single(make_r(cpu_types_pkg::ADD, 5'd1, 5'd2, 5'd0, 5'd0), 32'h5, 32'h6);
  endtask

  task automatic burst_in_order();
    cpu_types_pkg::instr_u w;
    logic [31:0]           a;
    logic [31:0]           b;
    int                    i;
    for (i = 0; i < 16; i++)
    begin
      w = rand_instr();
      a = next_rand();
      b = next_rand();
      issue(w, a, b);
    end
    drain();
  endtask

  initial
  begin
    arst_n_i  = 1'b0;
    valid_i   = 1'b0;
    instr_i   = '0;
    rs_data_i = '0;
    rt_data_i = '0;
    reset_quiet();
    rtype_ops();
    itype_ops();
    trap_cases();
    burst_in_order();
    repeat (4) @(posedge CLK);
    if (exp_q.size() == 0)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      $display("%0d results never came out", exp_q.size());
      $display("Simulation FAILED");
      $fatal(1, "results outstanding at the end");
    end
  end

endmodule
